// File: Makefile
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@test -f $(LOG) || { echo "No log file $(LOG), run the simulation first"; exit 1; }
	@if grep -q "Checks failed" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/rv_mem_pkg.sv
package rv_mem_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int LANES       = XLEN / 8;      // Byte lanes per word
    localparam int MEM_INDEX_W = 8;
    localparam int MEM_WORDS   = 256;           // Shared memory depth in words
    localparam int WORD_BYTES  = LANES;         // PC step between instructions

    typedef logic [XLEN-1:0]        word_t;
    typedef logic [XLEN-1:0]        addr_t;
    typedef logic [LANES-1:0]       mask_t;
    typedef logic [6:0]             opcode_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [MEM_INDEX_W-1:0] mem_index_t;

    // ------------------------------------------------------------
    // Major opcodes handled by the load/store unit
    // ------------------------------------------------------------
    localparam opcode_t OPC_LOAD  = 7'b00_000_11;
    localparam opcode_t OPC_STORE = 7'b01_000_11;

    // Width and sign selector
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

    // Load/store unit sequencing
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RESPONSE
    } lsu_state_t;

endpackage

// File: compile.f
common/rv_mem_pkg.sv
lsu/load_store_unit.sv
logic/fetch_unit.sv
logic/memory_arbiter.sv
logic/byte_lane_memory.sv
logic/mem_subsystem_top.sv
tb/mem_subsystem_properties.sv
tb/tb_mem_subsystem.sv

// File: logic/byte_lane_memory.sv
module byte_lane_memory
    import rv_mem_pkg::*;
(
    input  logic       clk,
    input  logic       mem_en,
    input  logic       mem_we,
    input  mask_t      mem_wmask,
    input  mem_index_t mem_index,
    input  word_t      mem_wdata,
    output word_t      mem_rdata
);
    word_t mem [MEM_WORDS];

    // ------------------------------------------------------------
    // Masked write, registered read
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (mem_en)
        begin
            if (mem_we)
            begin
                for (int k = 0; k < LANES; k++)
                begin
                    if (mem_wmask[k])
                        mem[mem_index][8*k +: 8] <= mem_wdata[8*k +: 8];  // Lane k only
                end
            end
            else
                mem_rdata <= mem[mem_index];   // Valid in the next cycle
        end
    end

endmodule

// File: logic/fetch_unit.sv
module fetch_unit
    import rv_mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_en,
    input  addr_t fetch_pc_start,
    output logic  fetch_req,
    input  logic  fetch_gnt,
    output addr_t fetch_addr,
    input  word_t fetch_rdata,
    output word_t instr,
    output addr_t instr_pc,
    output logic  instr_valid
);
    logic  en_q;               // Enable of the previous cycle
    addr_t pc;                 // Next address to request
    addr_t pend_pc;            // Address of the word now returning
    logic  pend_valid;

    // Requests start one cycle after the enable edge, once pc is loaded
    assign fetch_req  = fetch_en & en_q;
    assign fetch_addr = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            en_q        <= 1'b0;
            pend_valid  <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            en_q        <= fetch_en;
            pend_valid  <= fetch_gnt;
            instr_valid <= pend_valid;
        end
    end

    // ------------------------------------------------------------
    // PC and return pipeline
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (fetch_en && !en_q)
            pc <= fetch_pc_start;
        else if (fetch_gnt)
            pc <= pc + addr_t'(WORD_BYTES);
        if (fetch_gnt)
            pend_pc <= pc;                 // Pairs the word with its PC
        if (pend_valid)
        begin
            instr    <= fetch_rdata;
            instr_pc <= pend_pc;
        end
    end

endmodule

// File: logic/mem_subsystem_top.sv
module mem_subsystem_top
    import rv_mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // Load/store unit
    input  logic    lsu_start,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  addr_t   address,
    input  word_t   store_data,
    output word_t   load_data,
    output logic    lsu_done,
    output logic    lsu_misaligned,
    // Fetch unit
    input  logic    fetch_en,
    input  addr_t   fetch_pc_start,
    output word_t   instr,
    output addr_t   instr_pc,
    output logic    instr_valid
);
    logic       lsu_req;
    logic       lsu_gnt;
    logic       lsu_we;
    addr_t      lsu_addr;
    mask_t      lsu_wmask;
    word_t      lsu_wdata;
    word_t      lsu_rdata;

    logic       fetch_req;
    logic       fetch_gnt;
    addr_t      fetch_addr;
    word_t      fetch_rdata;

    logic       mem_en;
    logic       mem_we;
    mask_t      mem_wmask;
    mem_index_t mem_index;
    word_t      mem_wdata;
    word_t      mem_rdata;

    // ------------------------------------------------------------
    // Peers
    // ------------------------------------------------------------
    load_store_unit u_lsu (
        .clk, .rst, .lsu_start, .opcode, .funct3, .address, .store_data,
        .load_data, .lsu_done, .lsu_misaligned,
        .lsu_req, .lsu_gnt, .lsu_we, .lsu_addr, .lsu_wmask, .lsu_wdata, .lsu_rdata
    );

    fetch_unit u_fetch (
        .clk, .rst, .fetch_en, .fetch_pc_start,
        .fetch_req, .fetch_gnt, .fetch_addr, .fetch_rdata,
        .instr, .instr_pc, .instr_valid
    );

    // Shared memory behind the arbiter
    memory_arbiter u_arb (
        .clk, .rst,
        .lsu_req, .lsu_addr, .lsu_we, .lsu_wmask, .lsu_wdata, .lsu_gnt, .lsu_rdata,
        .fetch_req, .fetch_addr, .fetch_gnt, .fetch_rdata,
        .mem_en, .mem_we, .mem_wmask, .mem_index, .mem_wdata, .mem_rdata
    );

    byte_lane_memory u_mem (
        .clk, .mem_en, .mem_we, .mem_wmask, .mem_index, .mem_wdata, .mem_rdata
    );

endmodule

// File: logic/memory_arbiter.sv
module memory_arbiter
    import rv_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Load/store unit side
    input  logic       lsu_req,
    input  addr_t      lsu_addr,
    input  logic       lsu_we,
    input  mask_t      lsu_wmask,
    input  word_t      lsu_wdata,
    output logic       lsu_gnt,
    output word_t      lsu_rdata,
    // Fetch side
    input  logic       fetch_req,
    input  addr_t      fetch_addr,
    output logic       fetch_gnt,
    output word_t      fetch_rdata,
    // Memory port
    output logic       mem_en,
    output logic       mem_we,
    output mask_t      mem_wmask,
    output mem_index_t mem_index,
    output word_t      mem_wdata,
    input  word_t      mem_rdata
);
    logic lsu_rd_q;            // Read data of the next cycle belongs to LSU
    logic fetch_rd_q;

    // Fixed priority, LSU first
    assign lsu_gnt   = lsu_req;
    assign fetch_gnt = fetch_req & ~lsu_req;

    assign mem_en    = lsu_req | fetch_req;
    assign mem_we    = lsu_req & lsu_we;
    assign mem_wmask = lsu_req ? lsu_wmask : '0;    // Fetch only reads
    assign mem_index = lsu_req ? lsu_addr[MEM_INDEX_W+1:2] : fetch_addr[MEM_INDEX_W+1:2];
    assign mem_wdata = lsu_wdata;

    // ------------------------------------------------------------
    // Owner of the read in flight
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lsu_rd_q   <= 1'b0;
            fetch_rd_q <= 1'b0;
        end
        else
        begin
            lsu_rd_q   <= lsu_gnt & ~lsu_we;
            fetch_rd_q <= fetch_gnt;
        end
    end

    assign lsu_rdata   = lsu_rd_q   ? mem_rdata : '0;
    assign fetch_rdata = fetch_rd_q ? mem_rdata : '0;

endmodule

// File: lsu/load_store_unit.sv
module load_store_unit
    import rv_mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    lsu_start,         // One-cycle pulse, taken in IDLE
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  addr_t   address,
    input  word_t   store_data,
    output word_t   load_data,
    output logic    lsu_done,
    output logic    lsu_misaligned,
    output logic    lsu_req,
    input  logic    lsu_gnt,
    output logic    lsu_we,
    output addr_t   lsu_addr,
    output mask_t   lsu_wmask,
    output word_t   lsu_wdata,
    input  word_t   lsu_rdata
);
    lsu_state_t state;

    logic       dec_valid;             // Known opcode and width
    logic       dec_misaligned;
    mask_t      dec_mask;
    word_t      dec_wdata;
    logic [1:0] byte_off;

    funct3_t    f3_q;                  // Latched width for the load path
    logic [1:0] off_q;
    word_t      shifted;
    word_t      ext_data;

    // ------------------------------------------------------------
    // Decode of the incoming operation
    // ------------------------------------------------------------
    always_comb
    begin
        byte_off       = address[1:0];
        dec_valid      = 1'b0;
        dec_misaligned = 1'b0;
        dec_mask       = '0;
        dec_wdata      = store_data;
        case (funct3)
            F3_BYTE, F3_BYTE_U:
            begin
                dec_valid = 1'b1;
                dec_mask  = mask_t'(4'b0001) << byte_off;
                dec_wdata = {4{store_data[7:0]}};      // Same byte on every lane
            end
            F3_HALF, F3_HALF_U:
            begin
                dec_valid      = 1'b1;
                dec_misaligned = byte_off[0];
                dec_mask       = mask_t'(4'b0011) << byte_off;
                dec_wdata      = {2{store_data[15:0]}};
            end
            F3_WORD:
            begin
                dec_valid      = 1'b1;
                dec_misaligned = |byte_off;
                dec_mask       = 4'b1111;
            end
            default: ;
        endcase
        // Unsigned widths exist for loads only
        if (opcode == OPC_STORE && funct3[2])
            dec_valid = 1'b0;
        else if (opcode != OPC_LOAD && opcode != OPC_STORE)
            dec_valid = 1'b0;
    end

    assign lsu_req = (state == REQUEST);

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state          <= IDLE;
            lsu_done       <= 1'b0;
            lsu_misaligned <= 1'b0;
        end
        else
        begin
            lsu_done       <= 1'b0;
            lsu_misaligned <= 1'b0;
            case (state)
                IDLE:
                    if (lsu_start)
                    begin
                        if (!dec_valid)
                            lsu_done <= 1'b1;          // Nothing to do
                        else if (dec_misaligned)
                        begin
                            lsu_misaligned <= 1'b1;
                            lsu_done       <= 1'b1;
                        end
                        else
                            state <= REQUEST;
                    end
                REQUEST:
                    if (lsu_gnt)
                    begin
                        if (lsu_we)
                        begin
                            lsu_done <= 1'b1;          // Store is written at the grant
                            state    <= IDLE;
                        end
                        else
                            state <= RESPONSE;
                    end
                RESPONSE:
                begin
                    lsu_done <= 1'b1;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Lane select and extension of returned data
    always_comb
    begin
        shifted = lsu_rdata >> {off_q, 3'b000};
        case (f3_q)
            F3_BYTE:   ext_data = {{24{shifted[7]}}, shifted[7:0]};
            F3_BYTE_U: ext_data = {24'b0, shifted[7:0]};
            F3_HALF:   ext_data = {{16{shifted[15]}}, shifted[15:0]};
            F3_HALF_U: ext_data = {16'b0, shifted[15:0]};
            default:   ext_data = shifted;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && lsu_start)
        begin
            lsu_addr  <= {address[31:2], 2'b00};
            lsu_we    <= (opcode == OPC_STORE);
            lsu_wmask <= dec_mask;
            lsu_wdata <= dec_wdata;
            f3_q      <= funct3;
            off_q     <= byte_off;
        end
        if (state == RESPONSE)
            load_data <= ext_data;
    end

endmodule

// File: tb/mem_subsystem_properties.sv
module mem_subsystem_properties (
    input logic clk,
    input logic rst,
    input logic lsu_req,
    input logic lsu_gnt,
    input logic fetch_req,
    input logic fetch_gnt,
    input logic mem_en
);
    timeunit 1ns;
    timeprecision 100ps;

    logic rst_q = 1'b0;        // Reset seen on the previous edge

    always @(posedge clk)
        rst_q <= rst;

    // ------------------------------------------------------------
    // Arbiter and memory port rules
    // ------------------------------------------------------------
    one_grant: assert property (@(posedge clk) disable iff (rst) !(lsu_gnt && fetch_gnt))
        else $error("Both peers granted in the same cycle");

    lsu_gnt_has_req: assert property (@(posedge clk) disable iff (rst) lsu_gnt |-> lsu_req)
        else $error("lsu_gnt without lsu_req");

    fetch_gnt_has_req: assert property (@(posedge clk) disable iff (rst) fetch_gnt |-> fetch_req)
        else $error("fetch_gnt without fetch_req");

    // Settled reset, first edge excluded
    no_mem_in_reset: assert property (@(posedge clk) (rst && rst_q) |-> !mem_en)
        else $error("mem_en high during reset");

    lsu_first: assert property (@(posedge clk) disable iff (rst) lsu_req |-> lsu_gnt)
        else $error("Pending lsu_req not granted in the same cycle");

endmodule

bind memory_arbiter mem_subsystem_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .lsu_req   (lsu_req),
    .lsu_gnt   (lsu_gnt),
    .fetch_req (fetch_req),
    .fetch_gnt (fetch_gnt),
    .mem_en    (mem_en)
);

// File: tb/tb_mem_subsystem.sv
module tb_mem_subsystem
    import rv_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_BUDGET = 1500;    // All tests together, with slack
    localparam int LSU_TIMEOUT  = 20;

    logic    clk = 1'b0;
    logic    rst;
    logic    lsu_start;
    opcode_t opcode;
    funct3_t funct3;
    addr_t   address;
    word_t   store_data;
    word_t   load_data;
    logic    lsu_done;
    logic    lsu_misaligned;
    logic    fetch_en;
    addr_t   fetch_pc_start;
    word_t   instr;
    addr_t   instr_pc;
    logic    instr_valid;

    integer     seed;
    int         check_count = 0;
    int         error_count = 0;
    logic [7:0] model_mem [MEM_WORDS*4];   // Byte image of the shared memory
    logic       fetch_watch = 1'b0;
    addr_t      fetch_expect_pc;
    int         fetch_seen;

    mem_subsystem_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Reference model, little-endian lanes
    // ------------------------------------------------------------
    function automatic int width_bytes(input funct3_t f3);
        case (f3)
            F3_BYTE, F3_BYTE_U: return 1;
            F3_HALF, F3_HALF_U: return 2;
            default:            return 4;
        endcase
    endfunction

    function automatic void model_store(input funct3_t f3, input addr_t addr, input word_t data);
        for (int k = 0; k < width_bytes(f3); k++)
            model_mem[int'(addr[9:0]) + k] = data[8*k +: 8];
    endfunction

    function automatic word_t model_load(input funct3_t f3, input addr_t addr);
        word_t raw;
        raw = '0;
        for (int k = 0; k < width_bytes(f3); k++)
            raw[8*k +: 8] = model_mem[int'(addr[9:0]) + k];
        case (f3)
            F3_BYTE: return {{24{raw[7]}}, raw[7:0]};
            F3_HALF: return {{16{raw[15]}}, raw[15:0]};
            default: return raw;                 // Unsigned and word, upper bytes zero
        endcase
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // LSU and fetch drivers
    // ------------------------------------------------------------
    task automatic lsu_op(input opcode_t op, input funct3_t f3, input addr_t addr,
                          input word_t data, output word_t rdata, output logic mis);
        int waited;
        @(posedge clk);
        #0.5;
        lsu_start  = 1'b1;
        opcode     = op;
        funct3     = f3;
        address    = addr;
        store_data = data;
        @(posedge clk);
        #0.5;
        lsu_start = 1'b0;
        waited    = 0;
        @(negedge clk);
        while (!lsu_done && waited < LSU_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!lsu_done)
        begin
            error_count++;
            $display("LSU gave no lsu_done within %0d cycles at %0t", LSU_TIMEOUT, $time);
        end
        rdata = load_data;
        mis   = lsu_misaligned;
    endtask

    task automatic do_store(input funct3_t f3, input addr_t addr, input word_t data);
        word_t rdata;
        logic  mis;
        lsu_op(OPC_STORE, f3, addr, data, rdata, mis);
        check_flag("lsu_misaligned", mis, 1'b0);
        model_store(f3, addr, data);
    endtask

    task automatic do_load(input funct3_t f3, input addr_t addr);
        word_t rdata;
        logic  mis;
        lsu_op(OPC_LOAD, f3, addr, '0, rdata, mis);
        check_flag("lsu_misaligned", mis, 1'b0);
        check_word("load_data", rdata, model_load(f3, addr));
    endtask

    task automatic misaligned_op(input opcode_t op, input funct3_t f3, input addr_t addr);
        word_t rdata;
        logic  mis;
        lsu_op(op, f3, addr, rand_word(), rdata, mis);
        check_flag("lsu_misaligned", mis, 1'b1);
    endtask

    task automatic start_fetch(input addr_t pc);
        @(posedge clk);
        #0.5;
        fetch_expect_pc = pc;
        fetch_seen      = 0;
        fetch_watch     = 1'b1;
        fetch_pc_start  = pc;
        fetch_en        = 1'b1;
    endtask

    task automatic wait_fetch(input int n);
        int waited = 0;
        while (fetch_seen < n && waited < 4 * n + 10)
        begin
            @(posedge clk);
            waited++;
        end
        if (fetch_seen < n)
        begin
            error_count++;
            $display("Fetch stalled with %0d of %0d instructions at %0t", fetch_seen, n, $time);
        end
    endtask

    task automatic stop_fetch();
        @(posedge clk);
        #0.5;
        fetch_en = 1'b0;
        repeat (4) @(posedge clk);             // Drain words still in flight
        fetch_watch = 1'b0;
    endtask

    // Every instruction must arrive in PC order with the model's word
    always @(negedge clk)
    begin
        if (!rst && instr_valid)
        begin
            if (!fetch_watch)
            begin
                error_count++;
                $display("instr_valid pulsed with no fetch running at %0t", $time);
            end
            else
            begin
                check_word("instr_pc", instr_pc, fetch_expect_pc);
                check_word("instr", instr, model_load(F3_WORD, fetch_expect_pc));
                fetch_expect_pc = fetch_expect_pc + 4;
                fetch_seen++;
            end
        end
    end

    task automatic finish_test(input string name, input int c0, input int e0);
        $display("%-12s %0d checks, %0d errors", name, check_count - c0, error_count - e0);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_reset();
        int c0 = check_count;
        int e0 = error_count;
        repeat (6)
        begin
            @(negedge clk);
            check_flag("lsu_done", lsu_done, 1'b0);
            check_flag("lsu_misaligned", lsu_misaligned, 1'b0);
            check_flag("instr_valid", instr_valid, 1'b0);
        end
        finish_test("reset", c0, e0);
    endtask

    task automatic test_word_rw();
        int    c0 = check_count;
        int    e0 = error_count;
        addr_t a;
        repeat (8)
        begin
            a = addr_t'(rand_word() & 32'h0000_00fc);
            do_store(F3_WORD, a, rand_word());
            do_load(F3_WORD, a);
        end
        finish_test("word_rw", c0, e0);
    endtask

    task automatic test_byte_half();
        int    c0 = check_count;
        int    e0 = error_count;
        addr_t base;
        word_t d;
        for (int w = 0; w < 2; w++)
        begin
            base = addr_t'(32'h140 + 4 * w);
            do_store(F3_WORD, base, rand_word());
            for (int off = 0; off < 4; off++)
            begin
                d = rand_word();
                if (w == 1)
                    d[7] = 1'b1;                   // Negative bytes on the second word
                do_store(F3_BYTE, base + addr_t'(off), d);
                do_load(F3_WORD, base);
                do_load(F3_BYTE, base + addr_t'(off));
                do_load(F3_BYTE_U, base + addr_t'(off));
            end
            for (int off = 0; off < 4; off += 2)
            begin
                d = rand_word();
                if (w == 1)
                    d[15] = 1'b1;
                do_store(F3_HALF, base + addr_t'(off), d);
                do_load(F3_WORD, base);
                do_load(F3_HALF, base + addr_t'(off));
                do_load(F3_HALF_U, base + addr_t'(off));
            end
        end
        finish_test("byte_half", c0, e0);
    endtask

    task automatic test_misaligned();
        int    c0 = check_count;
        int    e0 = error_count;
        addr_t base = 32'h180;
        do_store(F3_WORD, base, rand_word());
        misaligned_op(OPC_STORE, F3_HALF, base + 1);
        misaligned_op(OPC_STORE, F3_HALF, base + 3);
        misaligned_op(OPC_LOAD, F3_HALF, base + 1);
        misaligned_op(OPC_LOAD, F3_HALF_U, base + 3);
        misaligned_op(OPC_STORE, F3_WORD, base + 2);
        misaligned_op(OPC_LOAD, F3_WORD, base + 1);
        misaligned_op(OPC_STORE, F3_WORD, base + 3);
        do_load(F3_WORD, base);                    // Memory must be untouched
        finish_test("misaligned", c0, e0);
    endtask

    task automatic test_fetch();
        int c0 = check_count;
        int e0 = error_count;
        for (int i = 0; i < 16; i++)
            do_store(F3_WORD, addr_t'(32'h200 + 4 * i), rand_word());
        start_fetch(32'h200);
        wait_fetch(12);
        stop_fetch();
        finish_test("fetch", c0, e0);
    endtask

    task automatic test_contention();
        int      c0 = check_count;
        int      e0 = error_count;
        word_t   r;
        addr_t   a;
        funct3_t f3;
        for (int i = 0; i < 48; i++)
            do_store(F3_WORD, addr_t'(32'h300 + 4 * i), rand_word());
        start_fetch(32'h300);
        repeat (4)
        begin
            r = rand_word();
            a = addr_t'(r & 32'h0000_00fc);       // Away from the fetch region
            case (r[9:8])
                2'd0, 2'd1:
                begin
                    f3      = F3_BYTE;
                    a[1:0]  = r[11:10];
                end
                2'd2:
                begin
                    f3   = F3_HALF;
                    a[1] = r[10];
                end
                default: f3 = F3_WORD;
            endcase
            do_store(f3, a, rand_word());
            if (r[12] && f3 != F3_WORD)
                f3 = f3 | 3'b100;                  // Unsigned form of the same width
            do_load(f3, a);
        end
        stop_fetch();
        check_flag("fetch progress", fetch_seen >= 8, 1'b1);
        finish_test("contention", c0, e0);
    endtask

    initial
    begin
        seed           = 32'h8238afa7;
        rst            = 1'b1;
        lsu_start      = 1'b0;
        opcode         = '0;
        funct3         = '0;
        address        = '0;
        store_data     = '0;
        fetch_en       = 1'b0;
        fetch_pc_start = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst = 1'b0;
        test_reset();
        test_word_rw();
        test_byte_half();
        test_misaligned();
        test_fetch();
        test_contention();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(CYCLE_BUDGET * CLK_PERIOD + 200);
        $display("Watchdog expired at %0t before the tests completed", $time);
        $display("Checks failed");
        $finish;
    end

endmodule
